// File: common/ptr_mgr_config.svh
/*
  Build-time sizing for the buffer-pointer manager.
  Included by the package and by every module that needs a width or a count.
*/
`ifndef PTR_MGR_CONFIG_SVH
`define PTR_MGR_CONFIG_SVH

// Number of buffer pointers, a power of two
`define PTR_MGR_NUM_PTRS 8

// Pointer width, log2 of the pointer count
`define PTR_MGR_PTR_W 3

// Requester tag carried by an allocate
// Same width as a pointer so both views share one command word
`define PTR_MGR_TAG_W `PTR_MGR_PTR_W

`endif

// File: common/ptr_mgr_pkg.sv
/*
  Types shared by the pointer manager pipeline stages.
  Opcode, command word and response status encodings.
*/
`default_nettype none

`include "ptr_mgr_config.svh"

package ptr_mgr_pkg;

  // Command opcode
  typedef enum logic {
    op_alloc = 1'b0,
    op_free  = 1'b1
  } cmd_op_t;

  // One command word, read according to the opcode
  // op_alloc uses alloc_tag, op_free uses free_ptr
  typedef union packed {
    logic [`PTR_MGR_TAG_W-1:0] alloc_tag;
    logic [`PTR_MGR_PTR_W-1:0] free_ptr;
  } cmd_word_u;

  // Response status
  typedef enum logic [1:0] {
    st_ok    = 2'd0,
    // allocate found no free pointer
    st_empty = 2'd1,
    // free found the list already full, a double free
    st_full  = 2'd2
  } rsp_status_t;

endpackage : ptr_mgr_pkg

`default_nettype wire

// File: source/cmd_stage.sv
/*
  First pipeline stage of the pointer manager.
  Registers the incoming command strobe and drops anything that
  arrives while the free list is still filling.
*/
`default_nettype none

module cmd_stage (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  ready,
  input  wire logic                  cmd_valid,
  input  ptr_mgr_pkg::cmd_op_t       cmd_op,
  input  ptr_mgr_pkg::cmd_word_u     cmd_word,
  output logic                       s1_valid,
  output ptr_mgr_pkg::cmd_op_t       s1_op,
  output ptr_mgr_pkg::cmd_word_u     s1_word
);

  logic cmd_accept;

  // Only place where ready gates the command path
  assign cmd_accept = cmd_valid & ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= cmd_accept;
    end
  end

  // Payload follows the strobe, qualified downstream by s1_valid
  always_ff @(posedge clk) begin
    if (cmd_accept) begin
      s1_op   <= cmd_op;
      s1_word <= cmd_word;
    end
  end

  // Ready is sticky, so no command can be in stage 1 while the fill runs
  s1_quiet_during_fill_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    !ready |-> !s1_valid
  ) else $error("command reached stage 1 before free list was ready");

endmodule : cmd_stage

`default_nettype wire

// File: free_list/free_list_lifo.sv
/*
  Stack of free buffer pointers with its own reset-time fill.
  After reset it pushes 0..DEPTH-1, one per cycle, then raises ready.
  Pop returns the most recently pushed entry.
*/
`default_nettype none

module free_list_lifo #(
  parameter int DEPTH  = 8,
  parameter int DWIDTH = 3
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              push,
  input  wire logic [DWIDTH-1:0] push_data,
  input  wire logic              pop,
  output logic      [DWIDTH-1:0] pop_data,
  output logic                   empty,
  output logic                   full,
  output logic                   ready
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int SW = AW + 1;

  logic [DEPTH*DWIDTH-1:0] data;
  logic [AW-1:0]           wp;
  logic [AW-1:0]           wp_nxt;
  logic [AW-1:0]           wp_m1;
  logic [SW-1:0]           size;
  logic [SW-1:0]           size_nxt;
  logic [AW-1:0]           fill_cnt;
  logic                    fill_push;
  logic                    push_any;
  logic [DWIDTH-1:0]       wr_data;

  // Fill sequencer owns the write port until ready
  assign fill_push = ~ready;
  assign push_any  = fill_push | push;
  assign wr_data   = fill_push ? DWIDTH'(fill_cnt) : push_data;

  assign empty = (size == '0);
  assign full  = (size == SW'(DEPTH));

  // Top of stack sits one slot below the write pointer
  assign wp_m1    = wp - 1'b1;
  assign pop_data = data[wp_m1*DWIDTH +: DWIDTH];

  always_comb begin
    wp_nxt   = wp;
    size_nxt = size;
    if (push_any) begin
      wp_nxt   = wp_nxt + 1'b1;
      size_nxt = size_nxt + 1'b1;
    end
    if (pop) begin
      wp_nxt   = wp_nxt - 1'b1;
      size_nxt = size_nxt - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_any) begin
      data[wp*DWIDTH +: DWIDTH] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wp   <= '0;
      size <= '0;
    end else begin
      wp   <= wp_nxt;
      size <= size_nxt;
    end
  end

  // Fill counter, ready rises with the last fill push
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_cnt <= '0;
      ready    <= 1'b0;
    end else if (fill_push) begin
      fill_cnt <= fill_cnt + 1'b1;
      if (fill_cnt == AW'(DEPTH - 1)) begin
        ready <= 1'b1;
      end
    end
  end

  lifo_size_bound_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    size_nxt <= SW'(DEPTH)
  ) else $error("free list size would exceed %0d", DEPTH);

  lifo_no_pop_empty_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> (ready && !empty)
  ) else $error("pop on empty or filling free list");

endmodule : free_list_lifo

`default_nettype wire

// File: free_list/alloc_stage.sv
/*
  Second pipeline stage of the pointer manager.
  Decodes the command word, pops or pushes the free list and
  registers the outcome for the response stage.
*/
`default_nettype none

`include "ptr_mgr_config.svh"

module alloc_stage (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       s1_valid,
  input  ptr_mgr_pkg::cmd_op_t            s1_op,
  input  ptr_mgr_pkg::cmd_word_u          s1_word,
  output logic                            s2_valid,
  output ptr_mgr_pkg::cmd_op_t            s2_op,
  output ptr_mgr_pkg::rsp_status_t        s2_status,
  output logic [`PTR_MGR_TAG_W-1:0]       s2_tag,
  output logic [`PTR_MGR_PTR_W-1:0]       s2_ptr,
  output logic                            ready
);

  import ptr_mgr_pkg::*;

  logic                      do_alloc;
  logic                      do_free;
  logic                      lifo_push;
  logic                      lifo_pop;
  logic                      lifo_empty;
  logic                      lifo_full;
  logic [`PTR_MGR_PTR_W-1:0] lifo_pop_data;
  logic [`PTR_MGR_TAG_W-1:0] tag_nxt;
  rsp_status_t               status_nxt;

  assign do_alloc = s1_valid && (s1_op == op_alloc);
  assign do_free  = s1_valid && (s1_op == op_free);

  // Empty and full are tested here only
  assign lifo_pop  = do_alloc && !lifo_empty;
  assign lifo_push = do_free && !lifo_full;

  // Tag view is echoed on an allocate, nothing on a free
  assign tag_nxt = (s1_op == op_alloc) ? s1_word.alloc_tag : '0;

  always_comb begin
    status_nxt = st_ok;
    if (do_alloc && lifo_empty) begin
      status_nxt = st_empty;
    end else if (do_free && lifo_full) begin
      status_nxt = st_full;
    end
  end

  free_list_lifo #(
    .DEPTH  (`PTR_MGR_NUM_PTRS),
    .DWIDTH (`PTR_MGR_PTR_W)
  ) u_free_list (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (lifo_push),
    .push_data (s1_word.free_ptr),
    .pop       (lifo_pop),
    .pop_data  (lifo_pop_data),
    .empty     (lifo_empty),
    .full      (lifo_full),
    .ready     (ready)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  // Result payload, stack updates on this same edge
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_op     <= s1_op;
      s2_status <= status_nxt;
      s2_tag    <= tag_nxt;
      s2_ptr    <= lifo_pop_data;
    end
  end

endmodule : alloc_stage

`default_nettype wire

// File: source/rsp_stage.sv
/*
  Third pipeline stage of the pointer manager.
  Registers the response seen by the requester, with the pointer
  forced to zero unless an allocate succeeded.
*/
`default_nettype none

`include "ptr_mgr_config.svh"

module rsp_stage (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       s2_valid,
  input  ptr_mgr_pkg::cmd_op_t            s2_op,
  input  ptr_mgr_pkg::rsp_status_t        s2_status,
  input  wire logic [`PTR_MGR_TAG_W-1:0]  s2_tag,
  input  wire logic [`PTR_MGR_PTR_W-1:0]  s2_ptr,
  output logic                            rsp_valid,
  output ptr_mgr_pkg::cmd_op_t            rsp_op,
  output ptr_mgr_pkg::rsp_status_t        rsp_status,
  output logic [`PTR_MGR_TAG_W-1:0]       rsp_tag,
  output logic [`PTR_MGR_PTR_W-1:0]       rsp_ptr
);

  import ptr_mgr_pkg::*;

  logic alloc_ok;

  assign alloc_ok = (s2_op == op_alloc) && (s2_status == st_ok);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      rsp_op     <= s2_op;
      rsp_status <= s2_status;
      rsp_tag    <= s2_tag;
      // No stale stack data on failures or frees
      rsp_ptr    <= alloc_ok ? s2_ptr : '0;
    end
  end

  // Status must fit the opcode that produced it
  rsp_status_legal_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp_valid |->
      ((rsp_op == op_alloc) ? (rsp_status inside {st_ok, st_empty})
                            : (rsp_status inside {st_ok, st_full}))
  ) else $error("illegal status %0d for op %0d", rsp_status, rsp_op);

endmodule : rsp_stage

`default_nettype wire

// File: source/ptr_mgr_top.sv
/*
  Buffer-pointer manager top level.
  Three-stage pipeline: command register, free list, response register.
  One command per cycle, one response three cycles later.
*/
`default_nettype none

`include "ptr_mgr_config.svh"

module ptr_mgr_top (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       cmd_valid,
  input  ptr_mgr_pkg::cmd_op_t            cmd_op,
  input  ptr_mgr_pkg::cmd_word_u          cmd_word,
  output logic                            ready,
  output logic                            rsp_valid,
  output ptr_mgr_pkg::cmd_op_t            rsp_op,
  output ptr_mgr_pkg::rsp_status_t        rsp_status,
  output logic [`PTR_MGR_TAG_W-1:0]       rsp_tag,
  output logic [`PTR_MGR_PTR_W-1:0]       rsp_ptr
);

  // Stage 1 to stage 2
  logic                      s1_valid;
  ptr_mgr_pkg::cmd_op_t      s1_op;
  ptr_mgr_pkg::cmd_word_u    s1_word;

  // Stage 2 to stage 3
  logic                      s2_valid;
  ptr_mgr_pkg::cmd_op_t      s2_op;
  ptr_mgr_pkg::rsp_status_t  s2_status;
  logic [`PTR_MGR_TAG_W-1:0] s2_tag;
  logic [`PTR_MGR_PTR_W-1:0] s2_ptr;

  cmd_stage u_cmd_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .ready     (ready),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_word  (cmd_word),
    .s1_valid  (s1_valid),
    .s1_op     (s1_op),
    .s1_word   (s1_word)
  );

  alloc_stage u_alloc_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .s1_valid  (s1_valid),
    .s1_op     (s1_op),
    .s1_word   (s1_word),
    .s2_valid  (s2_valid),
    .s2_op     (s2_op),
    .s2_status (s2_status),
    .s2_tag    (s2_tag),
    .s2_ptr    (s2_ptr),
    .ready     (ready)
  );

  rsp_stage u_rsp_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .s2_valid   (s2_valid),
    .s2_op      (s2_op),
    .s2_status  (s2_status),
    .s2_tag     (s2_tag),
    .s2_ptr     (s2_ptr),
    .rsp_valid  (rsp_valid),
    .rsp_op     (rsp_op),
    .rsp_status (rsp_status),
    .rsp_tag    (rsp_tag),
    .rsp_ptr    (rsp_ptr)
  );

endmodule : ptr_mgr_top

`default_nettype wire

// File: dv/ptr_mgr_checker.sv
/*
  Response checker for the pointer manager testbench.
  Delays each expected response by the pipeline latency, compares it
  with the DUT outputs and times the rise of ready after reset.
*/
`default_nettype none

`include "ptr_mgr_config.svh"

module ptr_mgr_checker #(
  parameter int LATENCY = 3
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       ready,
  input  wire logic                       exp_valid,
  input  wire ptr_mgr_pkg::cmd_op_t       exp_op,
  input  wire ptr_mgr_pkg::rsp_status_t   exp_status,
  input  wire logic [`PTR_MGR_TAG_W-1:0]  exp_tag,
  input  wire logic [`PTR_MGR_PTR_W-1:0]  exp_ptr,
  input  wire logic                       rsp_valid,
  input  wire ptr_mgr_pkg::cmd_op_t       rsp_op,
  input  wire ptr_mgr_pkg::rsp_status_t   rsp_status,
  input  wire logic [`PTR_MGR_TAG_W-1:0]  rsp_tag,
  input  wire logic [`PTR_MGR_PTR_W-1:0]  rsp_ptr,
  output int                              error_count,
  output int                              rsp_count
);

  import ptr_mgr_pkg::*;

  logic                      d_valid  [0:LATENCY-1];
  cmd_op_t                   d_op     [0:LATENCY-1];
  rsp_status_t               d_status [0:LATENCY-1];
  logic [`PTR_MGR_TAG_W-1:0] d_tag    [0:LATENCY-1];
  logic [`PTR_MGR_PTR_W-1:0] d_ptr    [0:LATENCY-1];
  int                        errors = 0;
  int                        rsp_seen = 0;
  int                        fill_cycles = 0;
  logic                      ready_seen = 1'b0;

  assign error_count = errors;
  assign rsp_count   = rsp_seen;

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h at time %0t", name, got, want, $time);
      errors++;
    end
  endtask

  // Stage 0 captures what the DUT samples on the same edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < LATENCY; i++) begin
        d_valid[i] <= 1'b0;
      end
      fill_cycles <= 0;
    end else begin
      // Edges spent filling before ready is seen high
      if (!ready) begin
        fill_cycles <= fill_cycles + 1;
      end
      d_valid[0]  <= exp_valid;
      d_op[0]     <= exp_op;
      d_status[0] <= exp_status;
      d_tag[0]    <= exp_tag;
      d_ptr[0]    <= exp_ptr;
      for (int i = 1; i < LATENCY; i++) begin
        d_valid[i]  <= d_valid[i-1];
        d_op[i]     <= d_op[i-1];
        d_status[i] <= d_status[i-1];
        d_tag[i]    <= d_tag[i-1];
        d_ptr[i]    <= d_ptr[i-1];
      end
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      // One fill push per pointer, then ready stays high
      if (ready && !ready_seen) begin
        ready_seen = 1'b1;
        check_field("ready fill cycles", 32'(fill_cycles), 32'(`PTR_MGR_NUM_PTRS));
      end else if (!ready && ready_seen) begin
        $display("Ready fell at time %0t after the fill had completed", $time);
        errors++;
      end
      if (rsp_valid) begin
        rsp_seen++;
      end
      if (rsp_valid && !d_valid[LATENCY-1]) begin
        $display("Unexpected response at time %0t with no command %0d cycles before",
                 $time, LATENCY);
        errors++;
      end else if (!rsp_valid && d_valid[LATENCY-1]) begin
        $display("Missing response at time %0t for a command %0d cycles before",
                 $time, LATENCY);
        errors++;
      end else if (rsp_valid) begin
        check_field("rsp_op", 32'(rsp_op), 32'(d_op[LATENCY-1]));
        check_field("rsp_status", 32'(rsp_status), 32'(d_status[LATENCY-1]));
        // Tag carries meaning on an allocate only
        if (d_op[LATENCY-1] == op_alloc) begin
          check_field("rsp_tag", 32'(rsp_tag), 32'(d_tag[LATENCY-1]));
        end
        check_field("rsp_ptr", 32'(rsp_ptr), 32'(d_ptr[LATENCY-1]));
      end
    end
  end

endmodule : ptr_mgr_checker

`default_nettype wire

// File: dv/tb_ptr_mgr.sv
/*
  Testbench for the buffer-pointer manager.
  Strobes commands during the fill, then applies a table of commands
  and hands each expected response to the checker.
*/
`default_nettype none

`include "ptr_mgr_config.svh"

module tb_ptr_mgr;

  import ptr_mgr_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int MAX_GAP    = 1;
  localparam int LATENCY    = 3;

  logic                      clk;
  logic                      rst_n;
  logic                      cmd_valid;
  cmd_op_t                   cmd_op;
  cmd_word_u                 cmd_word;
  logic                      ready;
  logic                      rsp_valid;
  cmd_op_t                   rsp_op;
  rsp_status_t               rsp_status;
  logic [`PTR_MGR_TAG_W-1:0] rsp_tag;
  logic [`PTR_MGR_PTR_W-1:0] rsp_ptr;

  logic                      exp_valid;
  cmd_op_t                   exp_op;
  rsp_status_t               exp_status;
  logic [`PTR_MGR_TAG_W-1:0] exp_tag;
  logic [`PTR_MGR_PTR_W-1:0] exp_ptr;
  int                        error_count;
  int                        rsp_count;
  int                        seed = 67;

  // Stimulus table, one entry per command
  cmd_op_t                   row_op     [$];
  logic [`PTR_MGR_PTR_W-1:0] row_word   [$];
  rsp_status_t               row_status [$];
  logic [`PTR_MGR_PTR_W-1:0] row_ptr    [$];
  bit                        row_b2b    [$];

  ptr_mgr_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_word   (cmd_word),
    .ready      (ready),
    .rsp_valid  (rsp_valid),
    .rsp_op     (rsp_op),
    .rsp_status (rsp_status),
    .rsp_tag    (rsp_tag),
    .rsp_ptr    (rsp_ptr)
  );

  ptr_mgr_checker #(.LATENCY(LATENCY)) i_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .ready       (ready),
    .exp_valid   (exp_valid),
    .exp_op      (exp_op),
    .exp_status  (exp_status),
    .exp_tag     (exp_tag),
    .exp_ptr     (exp_ptr),
    .rsp_valid   (rsp_valid),
    .rsp_op      (rsp_op),
    .rsp_status  (rsp_status),
    .rsp_tag     (rsp_tag),
    .rsp_ptr     (rsp_ptr),
    .error_count (error_count),
    .rsp_count   (rsp_count)
  );

  task automatic add_row(input cmd_op_t op, input logic [`PTR_MGR_PTR_W-1:0] word,
                         input rsp_status_t status, input logic [`PTR_MGR_PTR_W-1:0] ptr,
                         input bit b2b);
    row_op.push_back(op);
    row_word.push_back(word);
    row_status.push_back(status);
    row_ptr.push_back(ptr);
    row_b2b.push_back(b2b);
  endtask

  task automatic load_table();
    // Fill order, the last fill push comes out first
    add_row(op_alloc, 3'd1, st_ok,    3'd7, 1'b1);
    add_row(op_alloc, 3'd2, st_ok,    3'd6, 1'b1);
    add_row(op_alloc, 3'd3, st_ok,    3'd5, 1'b1);
    add_row(op_alloc, 3'd4, st_ok,    3'd4, 1'b1);
    add_row(op_alloc, 3'd5, st_ok,    3'd3, 1'b1);
    add_row(op_alloc, 3'd6, st_ok,    3'd2, 1'b1);
    add_row(op_alloc, 3'd7, st_ok,    3'd1, 1'b1);
    add_row(op_alloc, 3'd0, st_ok,    3'd0, 1'b1);
    // Underflow
    add_row(op_alloc, 3'd6, st_empty, 3'd0, 1'b0);
    // LIFO reuse
    add_row(op_free,  3'd2, st_ok,    3'd0, 1'b0);
    add_row(op_free,  3'd5, st_ok,    3'd0, 1'b0);
    add_row(op_free,  3'd1, st_ok,    3'd0, 1'b0);
    add_row(op_alloc, 3'd3, st_ok,    3'd1, 1'b0);
    add_row(op_alloc, 3'd4, st_ok,    3'd5, 1'b0);
    add_row(op_alloc, 3'd5, st_ok,    3'd2, 1'b0);
    // Refill to eight entries, then a double free
    add_row(op_free,  3'd4, st_ok,    3'd0, 1'b0);
    add_row(op_free,  3'd6, st_ok,    3'd0, 1'b0);
    add_row(op_free,  3'd0, st_ok,    3'd0, 1'b0);
    add_row(op_free,  3'd3, st_ok,    3'd0, 1'b0);
    add_row(op_free,  3'd7, st_ok,    3'd0, 1'b0);
    add_row(op_free,  3'd1, st_ok,    3'd0, 1'b0);
    add_row(op_free,  3'd2, st_ok,    3'd0, 1'b0);
    add_row(op_free,  3'd5, st_ok,    3'd0, 1'b0);
    add_row(op_free,  3'd3, st_full,  3'd0, 1'b0);
    add_row(op_alloc, 3'd2, st_ok,    3'd5, 1'b0);
    // Back to back, each command depends on the one before
    add_row(op_free,  3'd5, st_ok,    3'd0, 1'b1);
    add_row(op_alloc, 3'd1, st_ok,    3'd5, 1'b1);
    add_row(op_free,  3'd0, st_ok,    3'd0, 1'b1);
    add_row(op_alloc, 3'd7, st_ok,    3'd0, 1'b1);
    add_row(op_free,  3'd6, st_ok,    3'd0, 1'b1);
    add_row(op_alloc, 3'd4, st_ok,    3'd6, 1'b1);
  endtask

  task automatic drive_idle();
    cmd_valid = 1'b0;
    exp_valid = 1'b0;
  endtask

  task automatic drive_row(input int i);
    cmd_valid  = 1'b1;
    cmd_op     = row_op[i];
    exp_valid  = 1'b1;
    exp_op     = row_op[i];
    exp_status = row_status[i];
    exp_ptr    = row_ptr[i];
    if (row_op[i] == op_alloc) begin
      cmd_word.alloc_tag = row_word[i];
      // Tag comes back unchanged
      exp_tag            = row_word[i];
    end else begin
      cmd_word.free_ptr = row_word[i];
      exp_tag           = '0;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    int limit;
    #1;
    limit = row_op.size() * (MAX_GAP + 1) + `PTR_MGR_NUM_PTRS + 20;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d clock periods, the run did not complete", limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int gap;
    int total_errors;
    load_table();
    cmd_valid  = 1'b0;
    cmd_op     = op_alloc;
    cmd_word   = '0;
    exp_valid  = 1'b0;
    exp_op     = op_alloc;
    exp_status = st_ok;
    exp_tag    = '0;
    exp_ptr    = '0;
    rst_n      = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    // Strobes during the fill must be dropped
    repeat (3) begin
      @(negedge clk);
      cmd_valid          = 1'b1;
      cmd_op             = op_alloc;
      cmd_word.alloc_tag = '1;
    end
    @(negedge clk);
    drive_idle();
    while (!ready) begin
      @(negedge clk);
    end
    foreach (row_op[i]) begin
      gap = $unsigned($random(seed)) % (MAX_GAP + 1);
      if (row_b2b[i]) begin
        gap = 0;
      end
      repeat (gap) begin
        @(negedge clk);
        drive_idle();
      end
      @(negedge clk);
      drive_row(i);
    end
    @(negedge clk);
    drive_idle();
    repeat (LATENCY + 2) @(negedge clk);

    total_errors = error_count;
    if (rsp_count != row_op.size()) begin
      $display("Response count wrong: saw %0d responses for %0d accepted commands",
               rsp_count, row_op.size());
      total_errors++;
    end
    $display("Errors: %0d from checker, %0d in total, %0d responses seen",
             error_count, total_errors, rsp_count);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_ptr_mgr

`default_nettype wire

// File: build.f
+incdir+common
common/ptr_mgr_pkg.sv
source/cmd_stage.sv
free_list/free_list_lifo.sv
free_list/alloc_stage.sv
source/rsp_stage.sv
source/ptr_mgr_top.sv
dv/ptr_mgr_checker.sv
dv/tb_ptr_mgr.sv

// File: Makefile
# Verilator build and run for the buffer-pointer manager testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_ptr_mgr
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG := Simulation finished: PASS
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, not the simulator exit code
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Test passed"; \
	else \
		echo "Test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
